/* src.f */
+incdir+include
design/wb_pkg.sv
design/wb_if.sv
design/wb_ack_timer.sv
design/wb_scratch_ram.sv
design/wb_gpio_regs.sv
design/wb_team_slots.sv
design/wb_decode_fsm.sv
design/wb_fabric_top.sv
tests/wb_fabric_props.sv
tests/wb_fabric_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= wb_fabric_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

# pass only when the pass line shows up in the output
check: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tests/wb_fabric_tb.sv */
// self-checking testbench that runs random bus cycles on the fabric top against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module wb_fabric_tb
    import wb_pkg::*;
();

    localparam int HALF_PERIOD = 2;
    localparam int DRIVE_DLY   = 1;
    localparam int ACK_LIMIT   = `WB_TIMEOUT_CYCLES + 8;
    localparam int DRAIN_LIMIT = 8;
    localparam int SRAM_WORDS  = `WB_SRAM_WORDS;
    localparam int SAW         = $clog2(SRAM_WORDS);
    localparam int TEAMS       = `WB_NUM_TEAMS;
    localparam int REGS        = `WB_TEAM_REGS;
    localparam int TW          = $clog2(TEAMS);
    localparam logic [31:0] SEED = 32'hfb75_6274;

    logic     CLK;
    logic     nRST;
    logic     wbs_cyc;
    logic     wbs_stb;
    logic     wbs_we;
    wb_addr_t wbs_adr;
    wb_data_t wbs_dat_w;
    wb_sel_t  wbs_sel;
    logic     wbs_ack;
    wb_data_t wbs_dat_r;
    wb_data_t gpio_in;
    wb_data_t gpio_out;
    wb_data_t gpio_oe;

    // shadow state of the reference model
    wb_data_t sram_model [SRAM_WORDS];
    wb_data_t team_model [TEAMS][REGS];
    wb_data_t out_model;
    wb_data_t oe_model;

    // pending compares with got and expected side by side
    logic [31:0] got_q [$];
    logic [31:0] exp_q [$];
    string       what_q [$];

    wb_fabric_top UUT (
        .CLK       (CLK),
        .nRST      (nRST),
        .wbs_cyc   (wbs_cyc),
        .wbs_stb   (wbs_stb),
        .wbs_we    (wbs_we),
        .wbs_adr   (wbs_adr),
        .wbs_dat_w (wbs_dat_w),
        .wbs_sel   (wbs_sel),
        .wbs_ack   (wbs_ack),
        .wbs_dat_r (wbs_dat_r),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .gpio_oe   (gpio_oe)
    );

    always #HALF_PERIOD CLK = ~CLK;

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic wb_data_t merge_lanes(input wb_data_t cur, input wb_data_t wdat,
                                             input wb_sel_t sel);
        wb_data_t res;
        res = cur;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) res[8*b +: 8] = wdat[8*b +: 8];
        end
        return res;
    endfunction

    // expected read data from the address map
    function automatic wb_data_t ref_read(input wb_addr_t adr);
        team_idx_t team;
        team = adr[19:16];
        case (adr[31:24])
            `WB_SRAM_BASE: return sram_model[adr[SAW+1:2]];
            `WB_GPIO_BASE: begin
                case (adr[15:2])
                    14'd0:   return out_model;
                    14'd1:   return oe_model;
                    14'd2:   return gpio_in;
                    default: return 32'h0;
                endcase
            end
            `WB_TEAM_BASE: begin
                if (int'(team) < TEAMS) return team_model[team[TW-1:0]][adr[3:2]];
                return `WB_ERR_DATA;
            end
            default: return `WB_ERR_DATA;
        endcase
    endfunction

    // cycles from request to manager ack
    function automatic int ref_latency(input wb_addr_t adr);
        team_idx_t team;
        team = adr[19:16];
        case (adr[31:24])
            `WB_SRAM_BASE, `WB_GPIO_BASE: return 3;
            `WB_TEAM_BASE: return (int'(team) < TEAMS) ? 3 : `WB_TIMEOUT_CYCLES + 2;
            default: return 2;
        endcase
    endfunction

    task automatic model_write(input wb_addr_t adr, input wb_data_t wdat, input wb_sel_t sel);
        team_idx_t team;
        team = adr[19:16];
        case (adr[31:24])
            `WB_SRAM_BASE: begin
                sram_model[adr[SAW+1:2]] = merge_lanes(sram_model[adr[SAW+1:2]], wdat, sel);
            end
            `WB_GPIO_BASE: begin
                // offset 8 and above are read only
                if (adr[15:2] == 14'd0) out_model = merge_lanes(out_model, wdat, sel);
                if (adr[15:2] == 14'd1) oe_model = merge_lanes(oe_model, wdat, sel);
            end
            `WB_TEAM_BASE: begin
                if (int'(team) < TEAMS) begin
                    team_model[team[TW-1:0]][adr[3:2]] =
                        merge_lanes(team_model[team[TW-1:0]][adr[3:2]], wdat, sel);
                end
            end
            default: ;
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %0t: %s, got %h expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic queue_compare(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        got_q.push_back(got);
        exp_q.push_back(exp);
        what_q.push_back(what);
    endtask

    // compare process drains everything queued since the last edge
    always @(posedge CLK) begin
        while (exp_q.size() > 0) begin
            check_value(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bus cycles
    //////////////////////////////////////////////////////////////////////

    // one classic cycle held until ack and dropped the cycle after
    task automatic run_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                             input wb_sel_t sel, output wb_data_t rdat, output int lat);
        int n;
        bit seen;
        @(posedge CLK);
        #DRIVE_DLY;
        wbs_cyc   = 1'b1;
        wbs_stb   = 1'b1;
        wbs_we    = we;
        wbs_adr   = adr;
        wbs_dat_w = wdat;
        wbs_sel   = sel;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < ACK_LIMIT) begin
            @(posedge CLK);
            #DRIVE_DLY;
            n++;
            if (wbs_ack) seen = 1'b1;
        end
        if (!seen) stop_on_error($sformatf("timeout: no ack for the cycle at address %h", adr));
        rdat = wbs_dat_r;
        lat  = n;
        @(posedge CLK);
        #DRIVE_DLY;
        wbs_cyc = 1'b0;
        wbs_stb = 1'b0;
        wbs_we  = 1'b0;
    endtask

    task automatic bus_write(input wb_addr_t adr, input wb_data_t wdat, input wb_sel_t sel);
        wb_data_t rd;
        int lat;
        run_cycle(1'b1, adr, wdat, sel, rd, lat);
        queue_compare(lat, ref_latency(adr), $sformatf("write latency at %h", adr));
        model_write(adr, wdat, sel);
    endtask

    task automatic bus_read(input wb_addr_t adr);
        wb_data_t exp;
        wb_data_t rd;
        int lat;
        exp = ref_read(adr);
        run_cycle(1'b0, adr, 32'h0, 4'hf, rd, lat);
        queue_compare(rd, exp, $sformatf("read data at %h", adr));
        queue_compare(lat, ref_latency(adr), $sformatf("read latency at %h", adr));
    endtask

    function automatic wb_data_t rand_word();
        return $urandom();
    endfunction

    function automatic wb_sel_t rand_sel();
        logic [31:0] r;
        r = $urandom();
        return r[3:0];
    endfunction

    // register k of team t with the team number in adr[19:16]
    function automatic wb_addr_t team_addr(input int t, input int k);
        return {`WB_TEAM_BASE, 4'h0, 4'(t), 12'h000, 4'(k * 4)};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        wb_addr_t    adr;
        logic [31:0] r;
        int          i;
        int          t;
        int          k;
        CLK       = 1'b0;
        nRST      = 1'b0;
        wbs_cyc   = 1'b0;
        wbs_stb   = 1'b0;
        wbs_we    = 1'b0;
        wbs_adr   = 32'h0;
        wbs_dat_w = 32'h0;
        wbs_sel   = 4'h0;
        gpio_in   = 32'h0;
        out_model = 32'h0;
        oe_model  = 32'h0;
        void'($urandom(SEED));
        repeat (4) @(posedge CLK);
        #DRIVE_DLY;
        nRST = 1'b1;
        queue_compare(gpio_out, 32'h0, "gpio_out after reset");
        queue_compare(gpio_oe, 32'h0, "gpio_oe after reset");

        // sram full fill then random byte writes with wrap
        for (i = 0; i < SRAM_WORDS; i++) begin
            adr = {`WB_SRAM_BASE, 24'(i * 4)};
            bus_write(adr, adr ^ 32'h5A3C_96E1, 4'hf);
        end
        for (i = 0; i < 48; i++) begin
            r = $urandom();
            bus_write({`WB_SRAM_BASE, r[23:2], 2'b00}, rand_word(), rand_sel());
        end
        for (i = 0; i < 48; i++) begin
            r = $urandom();
            bus_read({`WB_SRAM_BASE, r[23:2], 2'b00});
        end
        adr = {`WB_SRAM_BASE, 24'h00_0010};
        bus_write(adr, rand_word(), 4'hf);
        bus_read(adr + 32'(SRAM_WORDS * 4));
        bus_write(adr + 32'(SRAM_WORDS * 12), rand_word(), 4'h6);
        bus_read(adr);

        // gpio registers and input readback
        gpio_in = rand_word();
        adr = {`WB_GPIO_BASE, 24'h0};
        bus_write(adr, rand_word(), 4'hf);
        bus_write(adr, rand_word(), rand_sel());
        queue_compare(gpio_out, out_model, "gpio_out after write");
        bus_write(adr + 32'h4, rand_word(), 4'hf);
        bus_write(adr + 32'h4, rand_word(), rand_sel());
        queue_compare(gpio_oe, oe_model, "gpio_oe after write");
        bus_read(adr);
        bus_read(adr + 32'h4);
        bus_read(adr + 32'h8);
        // input register ignores writes
        bus_write(adr + 32'h8, rand_word(), 4'hf);
        gpio_in = rand_word();
        bus_read(adr + 32'h8);
        queue_compare(gpio_out, out_model, "gpio_out after readonly write");
        bus_read(adr + 32'hC);
        bus_read(adr + 32'h100);
        bus_read(adr + 32'hFFFC);

        // team banks get a fill and random writes before a full readback
        for (t = 0; t < TEAMS; t++) begin
            for (k = 0; k < REGS; k++) begin
                adr = team_addr(t, k);
                bus_write(adr, adr ^ 32'h1F2E_3D4C, 4'hf);
            end
        end
        for (i = 0; i < 40; i++) begin
            r = $urandom();
            t = int'(r[7:0]) % TEAMS;
            k = int'(r[9:8]);
            bus_write(team_addr(t, k), rand_word(), rand_sel());
        end
        bus_write(team_addr(2, 1), 32'h0123_4567, 4'hf);
        for (t = 0; t < TEAMS; t++) begin
            for (k = 0; k < REGS; k++) begin
                bus_read(team_addr(t, k));
            end
        end

        // unmapped region returns the error word after 2 cycles
        bus_read(32'h3400_0000);
        bus_read(32'h0000_0000);
        bus_write(32'h31FF_FFFC, rand_word(), 4'hf);

        // unpopulated teams run into the ack timer
        bus_read(team_addr(TEAMS, 0));
        bus_write(team_addr(TEAMS + 1, 2), rand_word(), 4'hf);
        bus_read(32'h300F_0004);
        // fabric still serves normal cycles
        bus_read({`WB_SRAM_BASE, 24'h00_0010});
        bus_read(team_addr(0, 0));

        i = 0;
        while (exp_q.size() > 0 && i < DRAIN_LIMIT) begin
            @(posedge CLK);
            i++;
        end
        if (exp_q.size() > 0) begin
            stop_on_error("timeout: compare queue was not drained");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/wb_fabric_props.sv */
// handshake assertions on the fabric top, attached to every wb_fabric_top by the bind below
`timescale 1ns/1ps
`default_nettype none

module wb_fabric_props (
    input  logic CLK,
    input  logic nRST,
    input  logic wbs_cyc,
    input  logic wbs_stb,
    input  logic wbs_ack,
    input  logic sram_stb,
    input  logic gpio_stb,
    input  logic team_stb
);

    // manager ack is a single pulse
    ack_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        wbs_ack |=> !wbs_ack)
        else $error("manager ack held longer than one cycle");

    // no ack outside an open cycle
    ack_in_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        wbs_ack |-> (wbs_cyc && wbs_stb))
        else $error("manager ack without cyc and stb");

    // at most one target strobed
    one_target: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0({sram_stb, gpio_stb, team_stb}))
        else $error("more than one target strobe high");

    // held quiet in reset
    ack_in_reset: assert property (@(posedge CLK)
        !nRST |-> !wbs_ack)
        else $error("manager ack high during reset");

endmodule

bind wb_fabric_top wb_fabric_props u_props (
    .CLK      (CLK),
    .nRST     (nRST),
    .wbs_cyc  (wbs_cyc),
    .wbs_stb  (wbs_stb),
    .wbs_ack  (wbs_ack),
    .sram_stb (sram_bus.stb),
    .gpio_stb (gpio_bus.stb),
    .team_stb (team_bus.stb)
);

`default_nettype wire

/* design/wb_fabric_top.sv */
// top of the peripheral fabric, plain wishbone manager and gpio pins, decoder plus three targets
`timescale 1ns/1ps
`default_nettype none

module wb_fabric_top
    import wb_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    // wishbone manager side
    input  logic     wbs_cyc,
    input  logic     wbs_stb,
    input  logic     wbs_we,
    input  wb_addr_t wbs_adr,
    input  wb_data_t wbs_dat_w,
    input  wb_sel_t  wbs_sel,
    output logic     wbs_ack,
    output wb_data_t wbs_dat_r,
    // gpio pins
    input  wb_data_t gpio_in,
    output wb_data_t gpio_out,
    output wb_data_t gpio_oe
);

    logic wait_en;
    logic expired;

    // one bus per target
    wb_if sram_bus ();
    wb_if gpio_bus ();
    wb_if team_bus ();

    wb_decode_fsm u_decode (
        .CLK      (CLK),
        .nRST     (nRST),
        .m_cyc    (wbs_cyc),
        .m_stb    (wbs_stb),
        .m_we     (wbs_we),
        .m_adr    (wbs_adr),
        .m_dat_w  (wbs_dat_w),
        .m_sel    (wbs_sel),
        .m_ack    (wbs_ack),
        .m_dat_r  (wbs_dat_r),
        .wait_en  (wait_en),
        .expired  (expired),
        .sram_bus (sram_bus.manager),
        .gpio_bus (gpio_bus.manager),
        .team_bus (team_bus.manager)
    );

    wb_ack_timer u_timer (
        .CLK     (CLK),
        .nRST    (nRST),
        .wait_en (wait_en),
        .expired (expired)
    );

    wb_scratch_ram u_sram (
        .CLK  (CLK),
        .nRST (nRST),
        .bus  (sram_bus.periph)
    );

    wb_gpio_regs u_gpio (
        .CLK      (CLK),
        .nRST     (nRST),
        .bus      (gpio_bus.periph),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    wb_team_slots u_teams (
        .CLK  (CLK),
        .nRST (nRST),
        .bus  (team_bus.periph)
    );

endmodule

`default_nettype wire

/* design/wb_decode_fsm.sv */
// address decode FSM that steers manager cycles to sram, gpio or team buses and registers the reply
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module wb_decode_fsm
    import wb_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    // external manager
    input  logic     m_cyc,
    input  logic     m_stb,
    input  logic     m_we,
    input  wb_addr_t m_adr,
    input  wb_data_t m_dat_w,
    input  wb_sel_t  m_sel,
    output logic     m_ack,
    output wb_data_t m_dat_r,
    // ack timer link
    output logic     wait_en,
    input  logic     expired,
    // target buses
    wb_if.manager    sram_bus,
    wb_if.manager    gpio_bus,
    wb_if.manager    team_bus
);

    dec_state_e state, next_state;
    wb_target_e tgt, next_tgt;
    logic       ack_q, next_ack;
    wb_data_t   dat_q, next_dat;
    logic       route;
    logic       sel_sram, sel_gpio, sel_team;
    logic       tgt_ack;
    wb_data_t   tgt_dat;

    // region from the upper address byte
    function automatic wb_target_e decode_target(input wb_addr_t adr);
        case (adr[31:24])
            `WB_SRAM_BASE: return TGT_SRAM;
            `WB_GPIO_BASE: return TGT_GPIO;
            `WB_TEAM_BASE: return TGT_TEAM;
            default:       return TGT_NONE;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // target bus steering
    //////////////////////////////////////////////////////////////////////

    // only the latched target sees the cycle, and only in route
    assign route    = (state == ST_ROUTE) && m_cyc && m_stb;
    assign sel_sram = route && (tgt == TGT_SRAM);
    assign sel_gpio = route && (tgt == TGT_GPIO);
    assign sel_team = route && (tgt == TGT_TEAM);

    assign sram_bus.cyc   = sel_sram;
    assign sram_bus.stb   = sel_sram;
    assign sram_bus.we    = sel_sram && m_we;
    assign sram_bus.adr   = sel_sram ? m_adr : '0;
    assign sram_bus.dat_w = sel_sram ? m_dat_w : '0;
    assign sram_bus.sel   = sel_sram ? m_sel : '0;

    assign gpio_bus.cyc   = sel_gpio;
    assign gpio_bus.stb   = sel_gpio;
    assign gpio_bus.we    = sel_gpio && m_we;
    assign gpio_bus.adr   = sel_gpio ? m_adr : '0;
    assign gpio_bus.dat_w = sel_gpio ? m_dat_w : '0;
    assign gpio_bus.sel   = sel_gpio ? m_sel : '0;

    assign team_bus.cyc   = sel_team;
    assign team_bus.stb   = sel_team;
    assign team_bus.we    = sel_team && m_we;
    assign team_bus.adr   = sel_team ? m_adr : '0;
    assign team_bus.dat_w = sel_team ? m_dat_w : '0;
    assign team_bus.sel   = sel_team ? m_sel : '0;

    // reply mux of the latched target
    always_comb begin
        case (tgt)
            TGT_SRAM: begin
                tgt_ack = sram_bus.ack;
                tgt_dat = sram_bus.dat_r;
            end
            TGT_GPIO: begin
                tgt_ack = gpio_bus.ack;
                tgt_dat = gpio_bus.dat_r;
            end
            TGT_TEAM: begin
                tgt_ack = team_bus.ack;
                tgt_dat = team_bus.dat_r;
            end
            default: begin
                tgt_ack = 1'b0;
                tgt_dat = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        next_tgt   = tgt;
        next_ack   = 1'b0;
        next_dat   = dat_q;
        case (state)
            ST_IDLE: begin
                if (m_cyc && m_stb) begin
                    next_tgt   = decode_target(m_adr);
                    next_state = ST_ROUTE;
                end
            end
            ST_ROUTE: begin
                // a real ack wins over a same-cycle timeout
                if (tgt_ack) begin
                    next_dat   = tgt_dat;
                    next_ack   = 1'b1;
                    next_state = ST_RESPOND;
                end else if ((tgt == TGT_NONE) || expired) begin
                    next_dat   = `WB_ERR_DATA;
                    next_ack   = 1'b1;
                    next_state = ST_RESPOND;
                end
            end
            // ack is up for this one cycle
            ST_RESPOND: next_state = ST_IDLE;
            default:    next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= ST_IDLE;
            tgt   <= TGT_NONE;
            ack_q <= 1'b0;
        end else begin
            state <= next_state;
            tgt   <= next_tgt;
            ack_q <= next_ack;
        end
    end

    // read data, qualified by ack
    always_ff @(posedge CLK) begin
        dat_q <= next_dat;
    end

    assign m_ack   = ack_q;
    assign m_dat_r = dat_q;
    assign wait_en = (state == ST_ROUTE);

endmodule

`default_nettype wire

/* design/wb_team_slots.sv */
// register banks of the populated teams, no ack at all for team numbers past the last one
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module wb_team_slots
    import wb_pkg::*;
(
    input  logic CLK,
    input  logic nRST,
    wb_if.periph bus
);

    localparam int TEAMS = `WB_NUM_TEAMS;
    localparam int REGS  = `WB_TEAM_REGS;
    localparam int TW    = $clog2(TEAMS);
    localparam int RW    = $clog2(REGS);

    wb_data_t      regs [TEAMS][REGS];
    wb_data_t      dat_q;
    logic          ack_q;
    logic          hit;
    logic          req;
    team_idx_t     team;
    logic [TW-1:0] slot;
    logic [RW-1:0] reg_idx;

    // team in adr[19:16], register in adr[3:2]
    assign team    = bus.adr[19:16];
    assign slot    = team[TW-1:0];
    assign reg_idx = bus.adr[RW+1:2];

    // unpopulated teams stay silent, the decoder times them out
    assign hit = (int'(team) < TEAMS);
    assign req = bus.cyc && bus.stb && hit && !ack_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_ff @(posedge CLK) begin
        if (req) begin
            if (bus.we) begin
                regs[slot][reg_idx] <= wb_merge_bytes(regs[slot][reg_idx], bus.dat_w, bus.sel);
            end
            dat_q <= regs[slot][reg_idx];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = dat_q;

endmodule

`default_nettype wire

/* design/wb_gpio_regs.sv */
// gpio output, direction and input readback registers behind a wishbone target port
`timescale 1ns/1ps
`default_nettype none

module wb_gpio_regs
    import wb_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    wb_if.periph     bus,
    input  wb_data_t gpio_in,
    output wb_data_t gpio_out,
    output wb_data_t gpio_oe
);

    logic        ack_q;
    logic        req;
    wb_data_t    dat_q;
    wb_data_t    out_q;
    wb_data_t    oe_q;
    logic [13:0] word;

    // word offset inside the 64k region
    assign word = bus.adr[15:2];
    assign req  = bus.cyc && bus.stb && !ack_q;

    //////////////////////////////////////////////////////////////////////
    // control registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ack_q <= 1'b0;
            out_q <= '0;
            oe_q  <= '0;
        end else begin
            ack_q <= req;
            if (req && bus.we) begin
                case (word)
                    14'd0:   out_q <= wb_merge_bytes(out_q, bus.dat_w, bus.sel);
                    14'd1:   oe_q  <= wb_merge_bytes(oe_q, bus.dat_w, bus.sel);
                    // input readback and the rest are read only
                    default: ;
                endcase
            end
        end
    end

    // readback, captured with the ack
    always_ff @(posedge CLK) begin
        if (req) begin
            case (word)
                14'd0:   dat_q <= out_q;
                14'd1:   dat_q <= oe_q;
                14'd2:   dat_q <= gpio_in;
                default: dat_q <= '0;
            endcase
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = dat_q;
    assign gpio_out  = out_q;
    assign gpio_oe   = oe_q;

endmodule

`default_nettype wire

/* design/wb_scratch_ram.sv */
// byte-enabled scratch word memory on a wishbone target port, read data registered with ack
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module wb_scratch_ram
    import wb_pkg::*;
(
    input  logic CLK,
    input  logic nRST,
    wb_if.periph bus
);

    localparam int DEPTH = `WB_SRAM_WORDS;
    localparam int AW    = $clog2(DEPTH);

    wb_data_t      mem [DEPTH];
    wb_data_t      dat_q;
    logic          ack_q;
    logic          req;
    logic [AW-1:0] idx;

    // word index, upper bits dropped so the space wraps
    assign idx = bus.adr[AW+1:2];

    // new request only while our ack is low
    assign req = bus.cyc && bus.stb && !ack_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // storage and read port
    always_ff @(posedge CLK) begin
        if (req) begin
            if (bus.we) begin
                mem[idx] <= wb_merge_bytes(mem[idx], bus.dat_w, bus.sel);
            end
            dat_q <= mem[idx];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = dat_q;

endmodule

`default_nettype wire

/* design/wb_ack_timer.sv */
// wait counter for routed cycles, flags a timeout to the decoder when no ack arrives
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module wb_ack_timer (
    input  logic CLK,
    input  logic nRST,
    input  logic wait_en,
    output logic expired
);

    localparam int LIMIT = `WB_TIMEOUT_CYCLES;
    localparam int CW    = $clog2(LIMIT + 1);

    logic [CW-1:0] count;
    logic          at_limit;

    assign at_limit = (count == CW'(LIMIT));

    // counts edges spent waiting, holds at the limit
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (!wait_en) begin
            // back to zero between cycles
            count <= '0;
        end else if (!at_limit) begin
            count <= count + 1'b1;
        end
    end

    // one cycle wide, the decoder leaves route on the next edge
    assign expired = wait_en && at_limit;

endmodule

`default_nettype wire

/* design/wb_if.sv */
// wishbone classic bus between the decoder and one target, one instance per target
`timescale 1ns/1ps
`default_nettype none

interface wb_if import wb_pkg::*; ();

    // request side
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_w;
    wb_sel_t  sel;

    // response side
    logic     ack;
    wb_data_t dat_r;

    // decoder end
    modport manager (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        output sel,
        input  ack,
        input  dat_r
    );

    // target end
    modport periph (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        input  sel,
        output ack,
        output dat_r
    );

endinterface

`default_nettype wire

/* design/wb_pkg.sv */
// bus types, state and target enums for the fabric, imported by wildcard where used
`default_nettype none

package wb_pkg;

    // wishbone vectors
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    // team number, taken from adr[19:16]
    typedef logic [3:0]  team_idx_t;

    // decoded destination of one cycle
    typedef enum logic [1:0] {
        TGT_SRAM,
        TGT_GPIO,
        TGT_TEAM,
        TGT_NONE
    } wb_target_e;

    // decoder states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ROUTE,
        ST_RESPOND
    } dec_state_e;

    // byte lane merge, sel picks lanes of wdat over cur
    function automatic wb_data_t wb_merge_bytes(input wb_data_t cur, input wb_data_t wdat,
                                                input wb_sel_t sel);
        wb_data_t res;
        res = cur;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = wdat[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

/* include/wb_params.svh */
// address map, sizes, timeout and error word of the wishbone fabric, included where needed
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// populated team slots and registers in each
`define WB_NUM_TEAMS 6
`define WB_TEAM_REGS 4

// scratch sram depth in 32-bit words
`define WB_SRAM_WORDS 64

// cycles a routed access may wait for a target ack
`define WB_TIMEOUT_CYCLES 16

// returned for unmapped addresses and timeouts
`define WB_ERR_DATA 32'hDEAD_BEEF

// upper address byte of each region
`define WB_SRAM_BASE 8'h33
`define WB_GPIO_BASE 8'h32
`define WB_TEAM_BASE 8'h30

`endif
